/* hw/bitstream_merge_stage.sv */
`timescale 1ns/1ns

module bitstream_merge_stage
#(
    parameter type t_seg_in  = bitstream_pkg::t_seg_row,
    parameter type t_seg_out = bitstream_pkg::t_seg_pair,
    parameter int  N_OUT     = 4
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_valid,
    input  t_seg_in  [2*N_OUT-1:0]      i_segs,
    output logic                        o_valid,
    output t_seg_out [N_OUT-1:0]        o_segs
);

    localparam int IN_BITS_W  = $bits(i_segs[0].bits);
    localparam int IN_LEN_W   = $bits(i_segs[0].len);
    localparam int OUT_BITS_W = $bits(o_segs[0].bits);
    localparam int OUT_LEN_W  = $bits(o_segs[0].len);

    t_seg_out [N_OUT-1:0] merged;

    // the even segment keeps the low bits, the odd one lands right above it
    always_comb
    begin
        for (int k = 0; k < N_OUT; k++)
        begin
            merged[k].bits = {{(OUT_BITS_W-IN_BITS_W){1'b0}}, i_segs[2*k].bits}
                           | ({{(OUT_BITS_W-IN_BITS_W){1'b0}}, i_segs[2*k+1].bits}
                              << i_segs[2*k].len);
            merged[k].len  = {{(OUT_LEN_W-IN_LEN_W){1'b0}}, i_segs[2*k].len}
                           + {{(OUT_LEN_W-IN_LEN_W){1'b0}}, i_segs[2*k+1].len};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        o_segs <= merged;
    end

    for (genvar k = 0; k < N_OUT; k++)
    begin : g_len_check
        a_len_fits: assert property (@(posedge clk) disable iff (!rst_n)
            i_valid |-> (merged[k].len <= OUT_BITS_W))
            else $error("merge stage: merged length overflows segment %0d", k);
    end

endmodule

/* hw/bitstream_pkg.sv */
`include "flag_codec_config.svh"

// variable length bit segments at each level of the merge tree
package bitstream_pkg;

    // a length field must hold the full width of its own bits field
    localparam int ROW_LEN_W  = $clog2(`ROW_SEG_W + 1);
    localparam int PAIR_LEN_W = ROW_LEN_W + 1;
    localparam int QUAD_LEN_W = PAIR_LEN_W + 1;
    localparam int TILE_LEN_W = QUAD_LEN_W + 1;

    typedef struct packed
    {
        logic [`ROW_SEG_W-1:0]      bits;
        logic [ROW_LEN_W-1:0]       len;
    } t_seg_row;

    typedef struct packed
    {
        logic [2*`ROW_SEG_W-1:0]    bits;
        logic [PAIR_LEN_W-1:0]      len;
    } t_seg_pair;

    typedef struct packed
    {
        logic [4*`ROW_SEG_W-1:0]    bits;
        logic [QUAD_LEN_W-1:0]      len;
    } t_seg_quad;

    typedef struct packed
    {
        logic [`TILE_STREAM_W-1:0]  bits;
        logic [TILE_LEN_W-1:0]      len;
    } t_seg_tile;

endpackage

/* hw/flag_code_pkg.sv */
`include "flag_codec_config.svh"

// types that describe the tile as it enters the compressor
package flag_code_pkg;

    typedef logic [`FLAG_W-1:0] t_flag;

    // value 2 is reserved and never encoded
    typedef enum logic [1:0]
    {
        UNIFORM     = 2'd0,
        SINGLE_DIFF = 2'd1,
        RAW         = 2'd3
    } t_row_mode;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one row as delivered by the upstream classifier
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // diff_pos, diff_flag and same_flag only matter in SINGLE_DIFF mode
    typedef struct packed
    {
        t_row_mode                  mode;
        logic [`POS_W-1:0]          diff_pos;
        t_flag                      diff_flag;
        t_flag                      same_flag;
        t_flag [`TILE_SIZE-1:0]     flags;
    } t_row_desc;

    // row 0 sits in the low bits
    typedef t_row_desc [`TILE_SIZE-1:0] t_tile_in;

endpackage

/* hw/flag_codec_config.svh */
`ifndef FLAG_CODEC_CONFIG_SVH
`define FLAG_CODEC_CONFIG_SVH

// tile geometry, one tile is TILE_SIZE rows of TILE_SIZE flags
`define TILE_SIZE       8
`define FLAG_W          3
`define POS_W           3

// longest prefix code in the flag code table
`define MAX_CODE_W      5

// a raw row is two mode bits followed by eight longest codes
`define ROW_SEG_W       (2 + `TILE_SIZE * `MAX_CODE_W)
`define TILE_STREAM_W   (`ROW_SEG_W * `TILE_SIZE)

// enough for the worst case of 42 bytes
`define BYTE_CNT_W      6

// row encode, three merge levels and the output register
`define PIPE_LATENCY    5

`endif

/* hw/flag_tile_compressor.sv */
`timescale 1ns/1ns
`include "flag_codec_config.svh"

module flag_tile_compressor
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_valid,
    input  flag_code_pkg::t_tile_in         i_tile,
    output logic                            o_valid,
    output logic [`TILE_STREAM_W-1:0]       o_stream,
    output logic [`BYTE_CNT_W-1:0]          o_byte_size
);

    logic row_valid;
    logic pair_valid;
    logic quad_valid;
    logic tile_valid;

    bitstream_pkg::t_seg_row  [`TILE_SIZE-1:0]   row_segs;
    bitstream_pkg::t_seg_pair [`TILE_SIZE/2-1:0] pair_segs;
    bitstream_pkg::t_seg_quad [`TILE_SIZE/4-1:0] quad_segs;
    bitstream_pkg::t_seg_tile [0:0]              tile_seg;

    row_encode_stage u_row_encode_stage
    (
        .clk(clk), .rst_n(rst_n),
        .i_valid(i_valid), .i_tile(i_tile),
        .o_valid(row_valid), .o_segs(row_segs)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // merge tree, rows to pairs to quads to the whole tile
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    bitstream_merge_stage #(.t_seg_in(bitstream_pkg::t_seg_row),
                            .t_seg_out(bitstream_pkg::t_seg_pair),
                            .N_OUT(`TILE_SIZE/2)) u_merge_pair
    (
        .clk(clk), .rst_n(rst_n),
        .i_valid(row_valid), .i_segs(row_segs),
        .o_valid(pair_valid), .o_segs(pair_segs)
    );

    bitstream_merge_stage #(.t_seg_in(bitstream_pkg::t_seg_pair),
                            .t_seg_out(bitstream_pkg::t_seg_quad),
                            .N_OUT(`TILE_SIZE/4)) u_merge_quad
    (
        .clk(clk), .rst_n(rst_n),
        .i_valid(pair_valid), .i_segs(pair_segs),
        .o_valid(quad_valid), .o_segs(quad_segs)
    );

    bitstream_merge_stage #(.t_seg_in(bitstream_pkg::t_seg_quad),
                            .t_seg_out(bitstream_pkg::t_seg_tile),
                            .N_OUT(1)) u_merge_tile
    (
        .clk(clk), .rst_n(rst_n),
        .i_valid(quad_valid), .i_segs(quad_segs),
        .o_valid(tile_valid), .o_segs(tile_seg)
    );

    tile_output_stage u_tile_output_stage
    (
        .clk(clk), .rst_n(rst_n),
        .i_valid(tile_valid), .i_seg(tile_seg[0]),
        .o_valid(o_valid), .o_stream(o_stream), .o_byte_size(o_byte_size)
    );

endmodule

/* hw/row_encode_stage.sv */
`timescale 1ns/1ns
`include "flag_codec_config.svh"

module row_encode_stage
(
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        i_valid,
    input  flag_code_pkg::t_tile_in                     i_tile,
    output logic                                        o_valid,
    output bitstream_pkg::t_seg_row [`TILE_SIZE-1:0]    o_segs
);

    bitstream_pkg::t_seg_row [`TILE_SIZE-1:0] row_segs;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // every row is encoded independently and in parallel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar r = 0; r < `TILE_SIZE; r++)
    begin : g_row
        row_encoder u_row_encoder
        (
            .clk        (clk),
            .i_check    (i_valid),
            .i_row      (i_tile[r]),
            .o_seg      (row_segs[r])
        );
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

    // segments load every cycle, valid tells the next stage what to trust
    always_ff @(posedge clk)
    begin
        o_segs <= row_segs;
    end

endmodule

/* hw/row_encoder.sv */
`timescale 1ns/1ns
`include "flag_codec_config.svh"

module row_encoder
(
    input  logic                        clk,
    input  logic                        i_check,
    input  flag_code_pkg::t_row_desc    i_row,
    output bitstream_pkg::t_seg_row     o_seg
);

    localparam int SEG_W      = `ROW_SEG_W;
    localparam int LEN_W      = bitstream_pkg::ROW_LEN_W;
    localparam int CODE_W     = `MAX_CODE_W;
    localparam int CODE_LEN_W = $clog2(`MAX_CODE_W + 1);
    localparam int SD_HDR_W   = 2 + `POS_W;

    logic [SEG_W-1:0]   raw_bits;
    logic [LEN_W-1:0]   raw_len;
    logic               raw_has_seven;
    logic               flag_bad;

    // prefix codes are sent lsb first
    function automatic logic [CODE_W-1:0] flag_code(input flag_code_pkg::t_flag f);
        case (f)
            3'd0:    flag_code = 5'd1;
            3'd1:    flag_code = 5'd0;
            3'd2:    flag_code = 5'd2;
            3'd3:    flag_code = 5'd3;
            3'd4:    flag_code = 5'd7;
            3'd5:    flag_code = 5'd15;
            3'd6:    flag_code = 5'd31;
            default: flag_code = 5'd0;
        endcase
    endfunction

    function automatic logic [CODE_LEN_W-1:0] flag_len(input flag_code_pkg::t_flag f);
        case (f)
            3'd0, 3'd1, 3'd2: flag_len = 3'd2;
            3'd3:             flag_len = 3'd3;
            3'd4:             flag_len = 3'd4;
            3'd5, 3'd6:       flag_len = 3'd5;
            default:          flag_len = 3'd0;
        endcase
    endfunction

    function automatic logic [SEG_W-1:0] seg_code(input flag_code_pkg::t_flag f);
        seg_code = {{(SEG_W-CODE_W){1'b0}}, flag_code(f)};
    endfunction

    // raw layout is the mode bits then all eight codes, row order from bit 2 up
    always_comb
    begin
        raw_bits      = {{(SEG_W-2){1'b0}}, i_row.mode};
        raw_len       = LEN_W'(2);
        raw_has_seven = 1'b0;
        for (int i = 0; i < `TILE_SIZE; i++)
        begin
            raw_bits      = raw_bits | (seg_code(i_row.flags[i]) << raw_len);
            raw_len       = raw_len + LEN_W'(flag_len(i_row.flags[i]));
            raw_has_seven = raw_has_seven | (i_row.flags[i] == '1);
        end
    end

    always_comb
    begin
        o_seg    = '0;
        flag_bad = 1'b0;
        case (i_row.mode)
            flag_code_pkg::UNIFORM:
            begin
                o_seg.bits = seg_code(i_row.flags[0]) << 1;
                o_seg.len  = LEN_W'(1) + LEN_W'(flag_len(i_row.flags[0]));
                flag_bad   = (i_row.flags[0] == '1);
            end
            flag_code_pkg::SINGLE_DIFF:
            begin
                o_seg.bits = {{(SEG_W-SD_HDR_W){1'b0}}, i_row.diff_pos, i_row.mode}
                           | (seg_code(i_row.diff_flag) << SD_HDR_W)
                           | (seg_code(i_row.same_flag) << (SD_HDR_W + flag_len(i_row.diff_flag)));
                o_seg.len  = LEN_W'(SD_HDR_W) + LEN_W'(flag_len(i_row.diff_flag))
                           + LEN_W'(flag_len(i_row.same_flag));
                flag_bad   = (i_row.diff_flag == '1) || (i_row.same_flag == '1);
            end
            flag_code_pkg::RAW:
            begin
                o_seg.bits = raw_bits;
                o_seg.len  = raw_len;
                flag_bad   = raw_has_seven;
            end
            default:
            begin
                o_seg = '0;
            end
        endcase
    end

    // the stage qualifies these with its own input valid
    a_no_flag_seven: assert property (@(posedge clk) i_check |-> !flag_bad)
        else $error("row encoder: flag value 7 used in an encoded position");

    a_mode_legal: assert property (@(posedge clk)
        i_check |-> (i_row.mode inside {flag_code_pkg::UNIFORM,
                                        flag_code_pkg::SINGLE_DIFF,
                                        flag_code_pkg::RAW}))
        else $error("row encoder: reserved row mode 2 on a valid tile");

endmodule

/* hw/tile_output_stage.sv */
`timescale 1ns/1ns
`include "flag_codec_config.svh"

module tile_output_stage
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_valid,
    input  bitstream_pkg::t_seg_tile        i_seg,
    output logic                            o_valid,
    output logic [`TILE_STREAM_W-1:0]       o_stream,
    output logic [`BYTE_CNT_W-1:0]          o_byte_size
);

    localparam int LEN_W  = bitstream_pkg::TILE_LEN_W;
    localparam int BYTE_W = `BYTE_CNT_W;

    logic [BYTE_W-1:0] byte_size;

    // round up, any bits past the last full byte need one more byte
    assign byte_size = i_seg.len[LEN_W-1:3] + BYTE_W'(|i_seg.len[2:0]);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

    // outputs read as zero between tiles
    always_ff @(posedge clk)
    begin
        o_stream    <= i_valid ? i_seg.bits : '0;
        o_byte_size <= i_valid ? byte_size : '0;
    end

    a_len_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        i_valid |-> (i_seg.len <= `TILE_STREAM_W))
        else $error("output stage: tile length %0d exceeds the stream width", i_seg.len);

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it, the exit status carries the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_flag_tile_compressor -f verilog.f \
    && ./obj_dir/Vtb_flag_tile_compressor \
    || exit 1

/* verification/tb_flag_model.svh */
`ifndef TB_FLAG_MODEL_SVH
`define TB_FLAG_MODEL_SVH

typedef logic [`TILE_STREAM_W-1:0] t_model_stream;

// prefix code of a flag value, its lsb is the first bit on the wire
function automatic int model_code(input int f);
    case (f)
        0:       return 1;
        1:       return 0;
        2:       return 2;
        3:       return 3;
        4:       return 7;
        5:       return 15;
        default: return 31;
    endcase
endfunction

function automatic int model_code_len(input int f);
    case (f)
        0, 1, 2: return 2;
        3:       return 3;
        4:       return 4;
        default: return 5;
    endcase
endfunction

// the merge tree is the same as writing rows one after another, row 0 at bit 0
function automatic void model_encode(input flag_code_pkg::t_tile_in tile,
                                     output t_model_stream stream, output int nbits);
    flag_code_pkg::t_row_desc row;
    int                       f;
    stream = '0;
    nbits  = 0;
    for (int r = 0; r < `TILE_SIZE; r++)
    begin
        row = tile[r];
        if (row.mode == flag_code_pkg::UNIFORM)
        begin
            // a single zero bit marks a uniform row
            f      = int'(row.flags[0]);
            nbits  = nbits + 1;
            stream = stream | (t_model_stream'(model_code(f)) << nbits);
            nbits  = nbits + model_code_len(f);
        end
        else if (row.mode == flag_code_pkg::SINGLE_DIFF)
        begin
            stream = stream | (t_model_stream'({row.diff_pos, 2'b01}) << nbits);
            nbits  = nbits + 5;
            f      = int'(row.diff_flag);
            stream = stream | (t_model_stream'(model_code(f)) << nbits);
            nbits  = nbits + model_code_len(f);
            f      = int'(row.same_flag);
            stream = stream | (t_model_stream'(model_code(f)) << nbits);
            nbits  = nbits + model_code_len(f);
        end
        else
        begin
            stream = stream | (t_model_stream'(2'b11) << nbits);
            nbits  = nbits + 2;
            for (int i = 0; i < `TILE_SIZE; i++)
            begin
                f      = int'(row.flags[i]);
                stream = stream | (t_model_stream'(model_code(f)) << nbits);
                nbits  = nbits + model_code_len(f);
            end
        end
    end
endfunction

function automatic int model_bytes(input int nbits);
    return (nbits + 7) / 8;
endfunction

`endif

/* verification/tb_flag_tile_compressor.sv */
`timescale 1ns/1ns
`include "flag_codec_config.svh"

module tb_flag_tile_compressor;

    localparam int N_VECTORS      = 6;
    localparam int N_RANDOM       = 20;
    localparam int TIMEOUT_CYCLES = N_VECTORS + N_RANDOM + `PIPE_LATENCY + 3 + 20;

    typedef struct packed
    {
        flag_code_pkg::t_tile_in    tile;
        logic [7:0]                 byte_size;
    } t_vector;

    typedef struct packed
    {
        logic [`TILE_STREAM_W-1:0]  stream;
        logic [`BYTE_CNT_W-1:0]     byte_size;
        logic [31:0]                due;
    } t_expect;

    logic                       clk;
    logic                       rst_n;
    logic                       i_valid;
    flag_code_pkg::t_tile_in    i_tile;
    logic                       o_valid;
    logic [`TILE_STREAM_W-1:0]  o_stream;
    logic [`BYTE_CNT_W-1:0]     o_byte_size;

    t_vector        vectors [N_VECTORS];
    t_expect        expect_q [$];
    int             cycle = 0;
    logic [31:0]    rng_state;
    logic           failed = 1'b0;

    `include "tb_flag_model.svh"

    flag_tile_compressor u_dut
    (
        .clk(clk), .rst_n(rst_n),
        .i_valid(i_valid), .i_tile(i_tile),
        .o_valid(o_valid), .o_stream(o_stream), .o_byte_size(o_byte_size)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES)
        begin
            $display("timeout: no end of test after %0d clock cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic report_mismatch(input string what);
        failed = 1'b1;
        $display("FAILED at %0t ns: %s", $time, what);
        $display("Errors found");
        $fatal(1, "stopping at the first error");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // row and tile builders
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic flag_code_pkg::t_row_desc uniform_row(input int f);
        flag_code_pkg::t_row_desc row;
        row           = '0;
        row.mode      = flag_code_pkg::UNIFORM;
        row.same_flag = 3'(f);
        for (int i = 0; i < `TILE_SIZE; i++)
            row.flags[i] = 3'(f);
        return row;
    endfunction

    function automatic flag_code_pkg::t_row_desc diff_row(input int pos, input int d,
                                                          input int s);
        flag_code_pkg::t_row_desc row;
        row            = uniform_row(s);
        row.mode       = flag_code_pkg::SINGLE_DIFF;
        row.diff_pos   = 3'(pos);
        row.diff_flag  = 3'(d);
        row.flags[pos] = 3'(d);
        return row;
    endfunction

    function automatic flag_code_pkg::t_row_desc raw_row(input int f);
        flag_code_pkg::t_row_desc row;
        row      = uniform_row(f);
        row.mode = flag_code_pkg::RAW;
        return row;
    endfunction

    // the upper half of the lcg state is the better half
    function automatic int next_rand(input int n);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'(rng_state[30:16]) % n;
    endfunction

    function automatic flag_code_pkg::t_tile_in random_tile();
        flag_code_pkg::t_tile_in tile;
        int                      kind;
        int                      pos;
        int                      same;
        for (int r = 0; r < `TILE_SIZE; r++)
        begin
            kind = next_rand(3);
            if (kind == 0)
                tile[r] = uniform_row(next_rand(7));
            else if (kind == 1)
            begin
                pos     = next_rand(8);
                same    = next_rand(7);
                tile[r] = diff_row(pos, (same + 1 + next_rand(6)) % 7, same);
            end
            else
            begin
                tile[r] = raw_row(0);
                for (int i = 0; i < `TILE_SIZE; i++)
                    tile[r].flags[i] = 3'(next_rand(7));
            end
        end
        return tile;
    endfunction

    task automatic build_table();
        flag_code_pkg::t_tile_in tile;
        // uniform rows with flag values 0 to 6 and then 0 make 33 bits
        for (int r = 0; r < `TILE_SIZE; r++)
            tile[r] = uniform_row(r % 7);
        vectors[0] = '{tile, 8'd5};
        // the odd flag moves along the row and the tile makes 91 bits
        for (int r = 0; r < `TILE_SIZE; r++)
            tile[r] = diff_row(r, r % 7, (r + 3) % 7);
        vectors[1] = '{tile, 8'd12};
        // every raw row walks through all flag values for 225 bits
        for (int r = 0; r < `TILE_SIZE; r++)
        begin
            tile[r] = raw_row(0);
            for (int i = 0; i < `TILE_SIZE; i++)
                tile[r].flags[i] = 3'((r + i) % 7);
        end
        vectors[2] = '{tile, 8'd29};
        for (int r = 0; r < `TILE_SIZE; r++)
            tile[r] = raw_row(6);
        vectors[3] = '{tile, 8'd42};
        // mixed modes adding up to exactly 80 bits
        tile[0] = uniform_row(0);
        tile[1] = diff_row(5, 6, 1);
        tile[2] = raw_row(1);
        tile[3] = uniform_row(4);
        tile[4] = diff_row(0, 2, 3);
        tile[5] = diff_row(7, 0, 1);
        tile[6] = raw_row(0);
        tile[7] = uniform_row(4);
        vectors[4] = '{tile, 8'd10};
        for (int r = 0; r < `TILE_SIZE; r++)
            tile[r] = uniform_row(1);
        vectors[5] = '{tile, 8'd3};
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_tile(input flag_code_pkg::t_tile_in tile, input int table_bytes);
        t_model_stream  stream;
        int             nbits;
        t_expect        e;
        model_encode(tile, stream, nbits);
        if (table_bytes >= 0)
        begin
            assert (table_bytes == model_bytes(nbits))
                else report_mismatch($sformatf("table byte count %0d, model gives %0d",
                                               table_bytes, model_bytes(nbits)));
        end
        e.stream    = stream;
        e.byte_size = `BYTE_CNT_W'(model_bytes(nbits));
        e.due       = 32'(cycle + `PIPE_LATENCY);
        expect_q.push_back(e);
        i_tile  = tile;
        i_valid = 1'b1;
    endtask

    always @(negedge clk)
    begin
        t_expect e;
        if (o_valid === 1'b1)
        begin
            assert (expect_q.size() > 0)
                else report_mismatch("o_valid high with no tile in flight");
            e = expect_q.pop_front();
            assert (cycle == int'(e.due))
                else report_mismatch($sformatf("tile out at cycle %0d, due %0d", cycle, e.due));
            assert (o_stream === e.stream)
                else report_mismatch($sformatf("o_stream %h, expected %h", o_stream, e.stream));
            assert (o_byte_size === e.byte_size)
                else report_mismatch($sformatf("o_byte_size %0d, expected %0d",
                                               o_byte_size, e.byte_size));
        end
        else if (cycle > 0)
        begin
            assert (o_valid === 1'b0)
                else report_mismatch("o_valid is neither high nor low");
            if (expect_q.size() > 0)
            begin
                assert (cycle < int'(expect_q[0].due))
                    else report_mismatch($sformatf("o_valid low at cycle %0d, tile due %0d",
                                                   cycle, expect_q[0].due));
            end
            // the output registers hold defined data from the second clock on
            if (cycle >= 2)
            begin
                assert (o_stream == '0 && o_byte_size == '0)
                    else report_mismatch("outputs not zero while o_valid is low");
            end
        end
    end

    initial
    begin
        rst_n     = 1'b0;
        i_valid   = 1'b0;
        i_tile    = '0;
        rng_state = 32'd33;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int v = 0; v < N_VECTORS; v++)
        begin
            drive_tile(vectors[v].tile, int'(vectors[v].byte_size));
            @(negedge clk);
        end
        // one idle cycle with junk on the tile bus
        i_valid = 1'b0;
        i_tile  = '1;
        @(negedge clk);
        for (int n = 0; n < N_RANDOM; n++)
        begin
            drive_tile(random_tile(), -1);
            @(negedge clk);
        end
        i_valid = 1'b0;
        i_tile  = '0;
        while (expect_q.size() != 0)
            @(negedge clk);
        @(negedge clk);
        if (!failed)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("Errors found");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* verilog.f */
+incdir+hw
+incdir+verification
hw/flag_code_pkg.sv
hw/bitstream_pkg.sv
hw/row_encoder.sv
hw/row_encode_stage.sv
hw/bitstream_merge_stage.sv
hw/tile_output_stage.sv
hw/flag_tile_compressor.sv
verification/tb_flag_tile_compressor.sv
